/* build.f */
source/blit_pkg.sv
source/image_mem.sv
source/raster_scan.sv
source/blit_sequencer.sv
source/pixel_path.sv
source/screen_blitter.sv
tests/tb_screen_blitter.sv

/* Bender.yml */
package:
  name: screen_blitter

sources:
  - source/blit_pkg.sv
  - source/image_mem.sv
  - source/raster_scan.sv
  - source/blit_sequencer.sv
  - source/pixel_path.sv
  - source/screen_blitter.sv
  - target: test
    files:
      - tests/tb_screen_blitter.sv

/* tests/tb_screen_blitter.sv */
`timescale 1ns/1ns

module tb_screen_blitter import blit_pkg::*; ();

	localparam int BG_N     = SCREEN_W * SCREEN_H;
	localparam int PL_N     = PLAYER_SZ * PLAYER_SZ;
	localparam int BR_N     = BARREL_SZ * BARREL_SZ;
	localparam int ROUNDS   = 8;
	localparam int LOAD_LEN = BG_N + PL_N + BR_N + 4;
	localparam int GO_LEN   = BG_N + PL_N + BR_N + 8;
	localparam int STEP_LEN = 2 * (PL_N + BR_N) + 8;
	// reset, idle check, three full loads, go round and step rounds
	localparam int TIMEOUT_CYCLES = 40 + 3 * LOAD_LEN + GO_LEN + ROUNDS * STEP_LEN + 1000;

	logic   clk;
	logic   resetn;
	logic   go;
	logic   step;
	pos_t   player_pos;
	pos_t   barrel_pos;
	logic   load_valid;
	load_t  load;
	pixel_t pixel_out;
	logic   plot;
	logic   ready;

	integer seed;
	int     mismatches = 0;
	int     failures = 0;
	int     cycle_cnt = 0;
	int     round_pixels = 0;
	logic   checking = 1'b0;
	logic   in_round = 1'b0;
	string  test_name = "reset";
	pos_t   old_player;
	pos_t   old_barrel;
	pixel_t exp_q[$];  // pixels still to come, in order
	color_t bg_model[BG_N];
	color_t pl_model[PL_N];
	color_t br_model[BR_N];

	screen_blitter dut0 (
		.clk        (clk),
		.resetn     (resetn),
		.go         (go),
		.step       (step),
		.player_pos (player_pos),
		.barrel_pos (barrel_pos),
		.load_valid (load_valid),
		.load       (load),
		.pixel_out  (pixel_out),
		.plot       (plot),
		.ready      (ready)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test failed");
		$finish;
	end

	task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
		if (act !== exp) begin
			mismatches++;
			$display("Mismatch %s: expected x=%0d y=%0d color=%0d, actual x=%0d y=%0d color=%0d",
				name, exp.x, exp.y, exp.color, act.x, act.y, act.color);
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			mismatches++;
			$display("Mismatch %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			mismatches++;
			$display("Mismatch %s: expected %0d pixels, actual %0d", name, exp, act);
		end
	endtask

	// outputs sampled mid-cycle
	always @(negedge clk) begin
		if (checking) begin
			if (plot === 1'b1) begin
				round_pixels++;
				if (exp_q.size() == 0) begin
					failures++;
					$display("%s: a pixel was plotted when none was expected", test_name);
				end else begin
					check_pixel(test_name, exp_q.pop_front(), pixel_out);
				end
			end
			if (in_round) begin
				check_level({test_name, " ready"}, exp_q.size() == 0, ready);
				if (ready) begin
					in_round = 1'b0;  // round over
				end
			end
		end
	end

	function automatic pos_t rand_pos(input int sz);
		pos_t p;
		p.x = coord_x_t'($unsigned($random(seed)) % (SCREEN_W - sz + 1));
		p.y = coord_y_t'($unsigned($random(seed)) % (SCREEN_H - sz + 1));
		return p;
	endfunction

	task automatic push_rect(input pos_t org, input int w, input int h, input img_sel_t src);
		pixel_t p;
		for (int r = 0; r < h; r++) begin
			for (int c = 0; c < w; c++) begin
				p.x = coord_x_t'(org.x + c);
				p.y = coord_y_t'(org.y + r);
				case (src)
					IMG_PLAYER: p.color = pl_model[r * PLAYER_SZ + c];
					IMG_BARREL: p.color = br_model[r * BARREL_SZ + c];
					default:    p.color = bg_model[p.y * SCREEN_W + p.x];  // screen copy
				endcase
				exp_q.push_back(p);
			end
		end
	endtask

	task automatic load_word(input img_sel_t sel, input int addr, input color_t data);
		@(posedge clk);
		#2;
		load_valid = 1'b1;
		load = '{sel: sel, addr: 15'(addr), data: data};
	endtask

	task automatic load_all();
		color_t c;
		check_level({test_name, " ready"}, 1'b1, ready);
		for (int i = 0; i < BG_N; i++) begin
			c = color_t'($random(seed));
			bg_model[i] = c;
			load_word(IMG_BG, i, c);
		end
		for (int i = 0; i < PL_N; i++) begin
			c = color_t'($random(seed));
			pl_model[i] = c;
			load_word(IMG_PLAYER, i, c);
		end
		for (int i = 0; i < BR_N; i++) begin
			c = color_t'($random(seed));
			br_model[i] = c;
			load_word(IMG_BARREL, i, c);
		end
		@(posedge clk);
		#2;
		load_valid = 1'b0;
	endtask

	task automatic run_round(input logic is_go);
		pos_t np;
		pos_t nb;
		int   n;
		int   k_go;
		int   k_step;
		int   expected;
		np = rand_pos(PLAYER_SZ);
		nb = rand_pos(BARREL_SZ);
		k_go = 2 + ($unsigned($random(seed)) % 20);  // stray pulses early in the round
		k_step = 2 + ($unsigned($random(seed)) % 20);
		@(posedge clk);
		#2;
		check_level({test_name, " ready before pulse"}, 1'b1, ready);
		go = is_go;
		step = !is_go;
		player_pos = np;
		barrel_pos = nb;
		round_pixels = 0;
		if (is_go) begin
			push_rect('0, SCREEN_W, SCREEN_H, IMG_BG);
		end else begin
			push_rect(old_barrel, BARREL_SZ, BARREL_SZ, IMG_BG);
			push_rect(old_player, PLAYER_SZ, PLAYER_SZ, IMG_BG);
		end
		push_rect(nb, BARREL_SZ, BARREL_SZ, IMG_BARREL);
		push_rect(np, PLAYER_SZ, PLAYER_SZ, IMG_PLAYER);
		expected = exp_q.size();
		old_player = np;
		old_barrel = nb;
		@(posedge clk);
		#2;
		go = 1'b0;
		step = 1'b0;
		in_round = 1'b1;
		n = 1;
		while (in_round) begin
			@(posedge clk);
			#2;
			n++;
			go = (n == k_go);
			step = (n == k_step);
			player_pos = 15'($random(seed));  // must not be sampled
			barrel_pos = 15'($random(seed));
		end
		go = 1'b0;
		step = 1'b0;
		check_count({test_name, " pixel count"}, expected, round_pixels);
		if (exp_q.size() != 0) begin
			failures++;
			$display("%s: round ended with %0d pixels never plotted", test_name, exp_q.size());
			exp_q.delete();
		end
	endtask

	initial begin
		seed = 68764;
		resetn = 1'b1;
		go = 1'b0;
		step = 1'b0;
		player_pos = '0;
		barrel_pos = '0;
		load_valid = 1'b0;
		load = '0;
		old_player = '0;
		old_barrel = '0;
		repeat (10) @(posedge clk);
		#2;
		resetn = 1'b0;
		checking = 1'b1;
		check_level("reset plot", 1'b0, plot);
		check_level("reset ready", 1'b1, ready);

		// step while idle does nothing
		test_name = "idle step";
		round_pixels = 0;
		step = 1'b1;
		player_pos = rand_pos(PLAYER_SZ);
		barrel_pos = rand_pos(BARREL_SZ);
		@(posedge clk);
		#2;
		step = 1'b0;
		repeat (20) begin
			@(posedge clk);
			#2;
			check_level("idle step ready", 1'b1, ready);
		end
		check_count("idle step", 0, round_pixels);

		test_name = "load";
		load_all();
		test_name = "go";
		run_round(1'b1);
		for (int i = 0; i < ROUNDS; i++) begin
			if (i == 3 || i == 6) begin
				test_name = $sformatf("reload %0d", i);
				load_all();
			end
			test_name = $sformatf("step %0d", i);
			run_round(1'b0);
		end
		test_name = "final idle";
		repeat (5) @(posedge clk);
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* source/screen_blitter.sv */
`timescale 1ns/1ns

module screen_blitter import blit_pkg::*; (
	input  logic   clk,
	input  logic   resetn,
	input  logic   go,
	input  logic   step,
	input  pos_t   player_pos,
	input  pos_t   barrel_pos,
	input  logic   load_valid,
	input  load_t  load,
	output pixel_t pixel_out,
	output logic   plot,
	output logic   ready
);

	logic     start;
	coord_x_t width;
	coord_y_t height;
	blit_op_t op;
	pos_t     origin;
	logic     active;
	coord_x_t col;
	coord_y_t row;
	logic     last;

	blit_sequencer seq0 (
		.clk        (clk),
		.resetn     (resetn),
		.go         (go),
		.step       (step),
		.player_pos (player_pos),
		.barrel_pos (barrel_pos),
		.last       (last),
		.start      (start),
		.width      (width),
		.height     (height),
		.op         (op),
		.origin     (origin),
		.ready      (ready)
	);

	raster_scan scan0 (
		.clk    (clk),
		.resetn (resetn),
		.start  (start),
		.width  (width),
		.height (height),
		.active (active),
		.col    (col),
		.row    (row),
		.last   (last)
	);

	pixel_path #(
		.BG_DEPTH     (SCREEN_W * SCREEN_H),
		.PLAYER_DEPTH (PLAYER_SZ * PLAYER_SZ),
		.BARREL_DEPTH (BARREL_SZ * BARREL_SZ)
	) path0 (
		.clk        (clk),
		.resetn     (resetn),
		.op         (op),
		.origin     (origin),
		.active     (active),
		.col        (col),
		.row        (row),
		.load_valid (load_valid),
		.load       (load),
		.pixel_out  (pixel_out),
		.plot       (plot)
	);

endmodule

/* source/pixel_path.sv */
`timescale 1ns/1ns

module pixel_path import blit_pkg::*; #(
	parameter int BG_DEPTH     = 19200,
	parameter int PLAYER_DEPTH = 81,
	parameter int BARREL_DEPTH = 25
) (
	input  logic     clk,
	input  logic     resetn,
	input  blit_op_t op,
	input  pos_t     origin,
	input  logic     active,
	input  coord_x_t col,
	input  coord_y_t row,
	input  logic     load_valid,
	input  load_t    load,
	output pixel_t   pixel_out,
	output logic     plot
);

	localparam int BG_AW = $clog2(BG_DEPTH);
	localparam int PL_AW = $clog2(PLAYER_DEPTH);
	localparam int BR_AW = $clog2(BARREL_DEPTH);

	coord_x_t          scr_x;
	coord_y_t          scr_y;
	logic [BG_AW-1:0]  y_ext;
	logic [BG_AW-1:0]  bg_raddr;
	logic [PL_AW-1:0]  sp_idx;
	logic              first_loc;
	color_t            bg_rdata;
	color_t            pl_rdata;
	color_t            br_rdata;
	color_t            color_sel;
	coord_x_t          x_d;
	coord_y_t          y_d;
	blit_op_t          op_d;
	logic              act_d;

	assign scr_x = origin.x + col;
	assign scr_y = origin.y + row;

	// y*160 + x as y*128 + y*32 + x
	assign y_ext    = BG_AW'(scr_y);
	assign bg_raddr = (y_ext << 7) + (y_ext << 5) + BG_AW'(scr_x);

	assign first_loc = (col == '0) && (row == '0);

	// sprite index restarts at the first location of each rectangle
	always_ff @(posedge clk) begin
		if (resetn || !active || first_loc) begin
			sp_idx <= PL_AW'(1);  // next read after address 0
		end else begin
			sp_idx <= sp_idx + PL_AW'(1);
		end
	end

	image_mem #(.DEPTH(BG_DEPTH)) bg_mem (
		.clk   (clk),
		.we    (load_valid && load.sel == IMG_BG),
		.waddr (load.addr[BG_AW-1:0]),
		.wdata (load.data),
		.raddr (bg_raddr),
		.rdata (bg_rdata)
	);

	image_mem #(.DEPTH(PLAYER_DEPTH)) player_mem (
		.clk   (clk),
		.we    (load_valid && load.sel == IMG_PLAYER),
		.waddr (load.addr[PL_AW-1:0]),
		.wdata (load.data),
		.raddr (first_loc ? PL_AW'(0) : sp_idx),
		.rdata (pl_rdata)
	);

	image_mem #(.DEPTH(BARREL_DEPTH)) barrel_mem (
		.clk   (clk),
		.we    (load_valid && load.sel == IMG_BARREL),
		.waddr (load.addr[BR_AW-1:0]),
		.wdata (load.data),
		.raddr (first_loc ? BR_AW'(0) : sp_idx[BR_AW-1:0]),
		.rdata (br_rdata)
	);

	always_ff @(posedge clk) begin
		x_d <= scr_x;  // aligned with memory read
		y_d <= scr_y;
	end

	always_ff @(posedge clk) begin
		if (resetn) begin
			op_d  <= OP_NONE;
			act_d <= 1'b0;
			plot  <= 1'b0;
		end else begin
			op_d  <= op;
			act_d <= active;
			plot  <= act_d;
		end
	end

	always_comb begin
		case (op_d)
			OP_DRAW_PLAYER: color_sel = pl_rdata;
			OP_DRAW_BARREL: color_sel = br_rdata;
			default:        color_sel = bg_rdata;  // background and erases
		endcase
	end

	always_ff @(posedge clk) begin
		pixel_out <= '{x: x_d, y: y_d, color: color_sel};
	end

endmodule

/* source/blit_sequencer.sv */
`timescale 1ns/1ns

module blit_sequencer import blit_pkg::*; (
	input  logic     clk,
	input  logic     resetn,
	input  logic     go,
	input  logic     step,
	input  pos_t     player_pos,
	input  pos_t     barrel_pos,
	input  logic     last,
	output logic     start,
	output coord_x_t width,
	output coord_y_t height,
	output blit_op_t op,
	output pos_t     origin,
	output logic     ready
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_BG,
		S_ERASE_BARREL,
		S_ERASE_PLAYER,
		S_DRAW_BARREL,
		S_DRAW_PLAYER,
		S_DRAIN,
		S_WAIT
	} state_t;

	state_t state;
	state_t state_nxt;
	logic   accept;
	pos_t   cur_player;
	pos_t   cur_barrel;
	pos_t   new_player;
	pos_t   new_barrel;

	assign accept = (state == S_IDLE && go) || (state == S_WAIT && step);
	assign ready  = (state == S_IDLE) || (state == S_WAIT);

	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE:         if (go) state_nxt = S_BG;
			S_WAIT:         if (step) state_nxt = S_ERASE_BARREL;
			S_BG:           if (last) state_nxt = S_DRAW_BARREL;
			S_ERASE_BARREL: if (last) state_nxt = S_ERASE_PLAYER;
			S_ERASE_PLAYER: if (last) state_nxt = S_DRAW_BARREL;
			S_DRAW_BARREL:  if (last) state_nxt = S_DRAW_PLAYER;
			S_DRAW_PLAYER:  if (last) state_nxt = S_DRAIN;
			S_DRAIN:        state_nxt = S_WAIT;  // last pixel leaves the pipe
			default:        state_nxt = S_IDLE;
		endcase
	end

	// next rectangle is launched in the cycle of the previous last
	assign start = accept || (last && state != S_DRAW_PLAYER);

	always_comb begin
		width  = coord_x_t'(BARREL_SZ);
		height = coord_y_t'(BARREL_SZ);
		case (state_nxt)
			S_BG: begin
				width  = coord_x_t'(SCREEN_W);
				height = coord_y_t'(SCREEN_H);
			end
			S_ERASE_PLAYER, S_DRAW_PLAYER: begin
				width  = coord_x_t'(PLAYER_SZ);
				height = coord_y_t'(PLAYER_SZ);
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (resetn) begin
			state <= S_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			new_player <= player_pos;
			new_barrel <= barrel_pos;
		end
		// old position stays until its erase is done
		if (start && state_nxt == S_DRAW_BARREL) begin
			cur_barrel <= new_barrel;
		end
		if (start && state_nxt == S_DRAW_PLAYER) begin
			cur_player <= new_player;
		end
	end

	always_comb begin
		op     = OP_NONE;
		origin = '0;
		case (state)
			S_BG: op = OP_BG;
			S_ERASE_BARREL: begin
				op     = OP_ERASE_BARREL;
				origin = cur_barrel;
			end
			S_ERASE_PLAYER: begin
				op     = OP_ERASE_PLAYER;
				origin = cur_player;
			end
			S_DRAW_BARREL: begin
				op     = OP_DRAW_BARREL;
				origin = cur_barrel;
			end
			S_DRAW_PLAYER: begin
				op     = OP_DRAW_PLAYER;
				origin = cur_player;
			end
			default: ;
		endcase
	end

endmodule

/* source/raster_scan.sv */
`timescale 1ns/1ns

module raster_scan import blit_pkg::*; (
	input  logic     clk,
	input  logic     resetn,
	input  logic     start,
	input  coord_x_t width,
	input  coord_y_t height,
	output logic     active,
	output coord_x_t col,
	output coord_y_t row,
	output logic     last
);

	coord_x_t col_max;
	coord_y_t row_max;

	// size is held for the whole rectangle
	always_ff @(posedge clk) begin
		if (start) begin
			col_max <= width - coord_x_t'(1);
			row_max <= height - coord_y_t'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (resetn) begin
			active <= 1'b0;
			col    <= '0;
			row    <= '0;
		end else if (start) begin
			// a new start wins over the end of the running scan
			active <= 1'b1;
			col    <= '0;
			row    <= '0;
		end else if (active) begin
			if (col == col_max) begin
				col <= '0;
				if (row == row_max) begin
					active <= 1'b0;
				end else begin
					row <= row + coord_y_t'(1);
				end
			end else begin
				col <= col + coord_x_t'(1);
			end
		end
	end

	assign last = active && (col == col_max) && (row == row_max);  // final location

endmodule

/* source/image_mem.sv */
`timescale 1ns/1ns

module image_mem import blit_pkg::*; #(
	parameter int DEPTH = 25
) (
	input  logic                     clk,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  color_t                   wdata,
	input  logic [$clog2(DEPTH)-1:0] raddr,
	output color_t                   rdata
);

	color_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr];  // old data on same-address write
	end

endmodule

/* source/blit_pkg.sv */
package blit_pkg;

	// screen and sprite geometry
	localparam int SCREEN_W  = 160;
	localparam int SCREEN_H  = 120;
	localparam int PLAYER_SZ = 9;
	localparam int BARREL_SZ = 5;

	typedef logic [2:0] color_t;
	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t;

	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
	} pos_t;

	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		color_t   color;
	} pixel_t;

	typedef enum logic [1:0] {
		IMG_BG,
		IMG_PLAYER,
		IMG_BARREL
	} img_sel_t;

	typedef struct packed {
		img_sel_t    sel;
		logic [14:0] addr;  // linear index into the selected image
		color_t      data;
	} load_t;

	typedef enum logic [2:0] {
		OP_NONE,
		OP_BG,
		OP_DRAW_PLAYER,
		OP_DRAW_BARREL,
		OP_ERASE_PLAYER,
		OP_ERASE_BARREL
	} blit_op_t;

endpackage
